/* design/rvpc_pkg.sv */
package rvpc_pkg;

   localparam int xlen       = 64;
   localparam int axi_addr_w = 8;
   localparam int axi_data_w = 32;

   typedef enum logic [2:0] {seq, branch, jal, jalr, trap} redirect_kind_e;

   // values follow branch funct3
   typedef enum logic [2:0] {
      beq  = 3'b000,
      bne  = 3'b001,
      none = 3'b010,
      blt  = 3'b100,
      bge  = 3'b101,
      bltu = 3'b110,
      bgeu = 3'b111
   } cmp_op_e;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_type_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_type_t;

   typedef struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_type_t;

   typedef union packed {
      b_type_t b;
      j_type_t j;
      i_type_t i;
   } instr_u;

   localparam logic [6:0]  op_branch = 7'b1100011;
   localparam logic [6:0]  op_jal    = 7'b1101111;
   localparam logic [6:0]  op_jalr   = 7'b1100111;
   localparam logic [6:0]  op_system = 7'b1110011;
   localparam logic [31:0] ebreak_word = 32'h0010_0073;

   localparam logic [axi_addr_w-1:0] reg_ctrl      = 8'h00;
   localparam logic [axi_addr_w-1:0] reg_boot_lo   = 8'h04;
   localparam logic [axi_addr_w-1:0] reg_boot_hi   = 8'h08;
   localparam logic [axi_addr_w-1:0] reg_trap_lo   = 8'h0c;
   localparam logic [axi_addr_w-1:0] reg_trap_hi   = 8'h10;
   localparam logic [axi_addr_w-1:0] reg_redirects = 8'h14;

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

endpackage

/* design/rvpc_cfg_if.sv */
`timescale 1ns/10ps

interface rvpc_cfg_if;

   logic [rvpc_pkg::xlen-1:0] boot_pc;
   logic [rvpc_pkg::xlen-1:0] trap_vector;
   logic                      restart;        // one-cycle pulse
   logic                      redirect_event; // one-cycle pulse

   modport csr (
      output boot_pc,
      output trap_vector,
      output restart,
      input  redirect_event
   );

   modport pc (
      input  boot_pc,
      input  trap_vector,
      input  restart,
      output redirect_event
   );

endinterface

/* design/rvpc_instr_decode.sv */
`timescale 1ns/10ps

module rvpc_instr_decode (
   input  rvpc_pkg::instr_u                instr,
   output rvpc_pkg::redirect_kind_e        redirect_kind,
   output logic [rvpc_pkg::xlen-1:0]       imm,
   output rvpc_pkg::cmp_op_e               cmp_op
);

   localparam int xlen = rvpc_pkg::xlen;

   logic [6:0] opcode;

   assign opcode = instr.i.opcode; // same bits in every view

   always_comb begin
      redirect_kind = rvpc_pkg::seq;
      imm           = '0;
      cmp_op        = rvpc_pkg::none;
      case (opcode)
         rvpc_pkg::op_branch: begin
            redirect_kind = rvpc_pkg::branch;
            imm = {{(xlen-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                   instr.b.imm4_1, 1'b0};
            case (instr.b.funct3)
               3'b000:  cmp_op = rvpc_pkg::beq;
               3'b001:  cmp_op = rvpc_pkg::bne;
               3'b100:  cmp_op = rvpc_pkg::blt;
               3'b101:  cmp_op = rvpc_pkg::bge;
               3'b110:  cmp_op = rvpc_pkg::bltu;
               3'b111:  cmp_op = rvpc_pkg::bgeu;
               default: cmp_op = rvpc_pkg::none; // never taken
            endcase
         end
         rvpc_pkg::op_jal: begin
            redirect_kind = rvpc_pkg::jal;
            imm = {{(xlen-20){instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                   instr.j.imm10_1, 1'b0};
         end
         rvpc_pkg::op_jalr: begin
            redirect_kind = rvpc_pkg::jalr;
            imm = {{(xlen-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};
         end
         rvpc_pkg::op_system: begin
            if (instr == rvpc_pkg::ebreak_word) begin
               redirect_kind = rvpc_pkg::trap;
            end
         end
         default: begin
            redirect_kind = rvpc_pkg::seq;
         end
      endcase
   end

endmodule

/* design/rvpc_branch_cmp.sv */
`timescale 1ns/10ps

module rvpc_branch_cmp (
   input  rvpc_pkg::cmp_op_e          cmp_op,
   input  logic [rvpc_pkg::xlen-1:0]  rs1_data,
   input  logic [rvpc_pkg::xlen-1:0]  rs2_data,
   output logic                       taken
);

   logic eq;
   logic lt;
   logic ltu;

   // one comparator of each kind, shared by all six conditions
   assign eq  = (rs1_data == rs2_data);
   assign lt  = ($signed(rs1_data) < $signed(rs2_data));
   assign ltu = (rs1_data < rs2_data);

   always_comb begin
      case (cmp_op)
         rvpc_pkg::beq:  taken = eq;
         rvpc_pkg::bne:  taken = !eq;
         rvpc_pkg::blt:  taken = lt;
         rvpc_pkg::bge:  taken = !lt;
         rvpc_pkg::bltu: taken = ltu;
         rvpc_pkg::bgeu: taken = !ltu;
         default:        taken = 1'b0; // none
      endcase
   end

endmodule

/* design/rvpc_next_pc.sv */
`timescale 1ns/10ps

module rvpc_next_pc #(
   parameter logic [rvpc_pkg::xlen-1:0] reset_boot_pc = 64'h8000_0000
) (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       instr_valid,
   input  rvpc_pkg::redirect_kind_e   redirect_kind,
   input  logic [rvpc_pkg::xlen-1:0]  imm,
   input  logic                       taken,
   input  logic [rvpc_pkg::xlen-1:0]  rs1_data,
   output logic [rvpc_pkg::xlen-1:0]  pc,
   output logic                       redirect,
   rvpc_cfg_if.pc                     cfg
);

   logic [rvpc_pkg::xlen-1:0] pc_seq;
   logic [rvpc_pkg::xlen-1:0] pc_rel;
   logic [rvpc_pkg::xlen-1:0] reg_rel;
   logic [rvpc_pkg::xlen-1:0] target;
   logic                      take;

   assign pc_seq  = pc + 64'd4;
   assign pc_rel  = pc + imm;
   assign reg_rel = rs1_data + imm;

   always_comb begin
      take   = 1'b1;
      target = pc_seq;
      case (redirect_kind)
         rvpc_pkg::branch: begin
            take   = taken;
            target = taken ? pc_rel : pc_seq;
         end
         rvpc_pkg::jal:  target = pc_rel;
         rvpc_pkg::jalr: target = {reg_rel[rvpc_pkg::xlen-1:1], 1'b0};
         rvpc_pkg::trap: target = cfg.trap_vector;
         default:        take   = 1'b0; // plain fall-through
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc       <= reset_boot_pc;
         redirect <= 1'b0;
      end else if (cfg.restart) begin
         pc       <= cfg.boot_pc; // wins over a valid instruction
         redirect <= 1'b0;
      end else if (instr_valid) begin
         pc       <= target;
         redirect <= take;
      end else begin
         redirect <= 1'b0;
      end
   end

   assign cfg.redirect_event = redirect;

endmodule

/* design/rvpc_csr_regs.sv */
`timescale 1ns/10ps

module rvpc_csr_regs #(
   parameter logic [rvpc_pkg::xlen-1:0] reset_boot_pc     = 64'h8000_0000,
   parameter logic [rvpc_pkg::xlen-1:0] reset_trap_vector = 64'h8000_0100
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [rvpc_pkg::axi_addr_w-1:0]    awaddr,
   input  logic                               awvalid,
   output logic                               awready,
   input  logic [rvpc_pkg::axi_data_w-1:0]    wdata,
   input  logic [rvpc_pkg::axi_data_w/8-1:0]  wstrb,
   input  logic                               wvalid,
   output logic                               wready,
   output logic [1:0]                         bresp,
   output logic                               bvalid,
   input  logic                               bready,
   input  logic [rvpc_pkg::axi_addr_w-1:0]    araddr,
   input  logic                               arvalid,
   output logic                               arready,
   output logic [rvpc_pkg::axi_data_w-1:0]    rdata,
   output logic [1:0]                         rresp,
   output logic                               rvalid,
   input  logic                               rready,
   rvpc_cfg_if.csr                            cfg
);

   localparam int dw = rvpc_pkg::axi_data_w;

   logic [dw-1:0] boot_lo;
   logic [dw-1:0] boot_hi;
   logic [dw-1:0] trap_lo;
   logic [dw-1:0] trap_hi;
   logic [dw-1:0] redirect_cnt;
   logic          wr_en;
   logic          rd_en;
   logic [dw-1:0] rd_value;
   logic          rd_hit;
   logic          wr_hit;

   function automatic logic [dw-1:0] merge_bytes(input logic [dw-1:0]   old_v,
                                                 input logic [dw-1:0]   new_v,
                                                 input logic [dw/8-1:0] strb);
      logic [dw-1:0] res;
      res = old_v;
      for (int b = 0; b < dw/8; b++) begin
         if (strb[b]) begin
            res[b*8 +: 8] = new_v[b*8 +: 8];
         end
      end
      return res;
   endfunction

   assign wr_en   = awvalid && wvalid && !bvalid;
   assign awready = wr_en;
   assign wready  = wr_en;
   assign rd_en   = arvalid && !rvalid;
   assign arready = rd_en;

   assign wr_hit = (awaddr inside {rvpc_pkg::reg_ctrl, rvpc_pkg::reg_boot_lo,
                                   rvpc_pkg::reg_boot_hi, rvpc_pkg::reg_trap_lo,
                                   rvpc_pkg::reg_trap_hi, rvpc_pkg::reg_redirects});

   always_comb begin
      rd_hit   = 1'b1;
      rd_value = '0;
      case (araddr)
         rvpc_pkg::reg_ctrl:      rd_value = '0; // write-only
         rvpc_pkg::reg_boot_lo:   rd_value = boot_lo;
         rvpc_pkg::reg_boot_hi:   rd_value = boot_hi;
         rvpc_pkg::reg_trap_lo:   rd_value = trap_lo;
         rvpc_pkg::reg_trap_hi:   rd_value = trap_hi;
         rvpc_pkg::reg_redirects: rd_value = redirect_cnt;
         default:                 rd_hit   = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         boot_lo     <= reset_boot_pc[dw-1:0];
         boot_hi     <= reset_boot_pc[2*dw-1:dw];
         trap_lo     <= reset_trap_vector[dw-1:0];
         trap_hi     <= reset_trap_vector[2*dw-1:dw];
         cfg.restart <= 1'b0;
         bvalid      <= 1'b0;
      end else begin
         cfg.restart <= wr_en && awaddr == rvpc_pkg::reg_ctrl && wstrb[0] && wdata[0];
         if (wr_en) begin
            bvalid <= 1'b1;
            case (awaddr)
               rvpc_pkg::reg_boot_lo: boot_lo <= merge_bytes(boot_lo, wdata, wstrb);
               rvpc_pkg::reg_boot_hi: boot_hi <= merge_bytes(boot_hi, wdata, wstrb);
               rvpc_pkg::reg_trap_lo: trap_lo <= merge_bytes(trap_lo, wdata, wstrb);
               rvpc_pkg::reg_trap_hi: trap_hi <= merge_bytes(trap_hi, wdata, wstrb);
               default: ; // ctrl and counter keep no written bits
            endcase
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         bresp <= wr_hit ? rvpc_pkg::resp_okay : rvpc_pkg::resp_slverr;
      end
      if (rd_en) begin
         rdata <= rd_value;
         rresp <= rd_hit ? rvpc_pkg::resp_okay : rvpc_pkg::resp_slverr;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid       <= 1'b0;
         redirect_cnt <= '0;
      end else begin
         if (rd_en) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         if (cfg.restart) begin
            redirect_cnt <= '0;
         end else if (cfg.redirect_event) begin
            redirect_cnt <= redirect_cnt + 1'b1; // wraps
         end
      end
   end

   assign cfg.boot_pc     = {boot_hi, boot_lo};
   assign cfg.trap_vector = {trap_hi, trap_lo};

endmodule

/* design/rvpc_top.sv */
`timescale 1ns/10ps

module rvpc_top #(
   parameter logic [rvpc_pkg::xlen-1:0] reset_boot_pc     = 64'h8000_0000,
   parameter logic [rvpc_pkg::xlen-1:0] reset_trap_vector = 64'h8000_0100
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               instr_valid,
   input  logic [31:0]                        instr,
   input  logic [rvpc_pkg::xlen-1:0]          rs1_data,
   input  logic [rvpc_pkg::xlen-1:0]          rs2_data,
   output logic [rvpc_pkg::xlen-1:0]          pc,
   output logic                               redirect,
   input  logic [rvpc_pkg::axi_addr_w-1:0]    awaddr,
   input  logic                               awvalid,
   output logic                               awready,
   input  logic [rvpc_pkg::axi_data_w-1:0]    wdata,
   input  logic [rvpc_pkg::axi_data_w/8-1:0]  wstrb,
   input  logic                               wvalid,
   output logic                               wready,
   output logic [1:0]                         bresp,
   output logic                               bvalid,
   input  logic                               bready,
   input  logic [rvpc_pkg::axi_addr_w-1:0]    araddr,
   input  logic                               arvalid,
   output logic                               arready,
   output logic [rvpc_pkg::axi_data_w-1:0]    rdata,
   output logic [1:0]                         rresp,
   output logic                               rvalid,
   input  logic                               rready
);

   rvpc_pkg::redirect_kind_e   redirect_kind;
   rvpc_pkg::cmp_op_e          cmp_op;
   logic [rvpc_pkg::xlen-1:0]  imm;
   logic                       taken;

   rvpc_cfg_if cfg_if_i ();

   rvpc_instr_decode rvpc_instr_decode_i (
      .instr         (instr),
      .redirect_kind (redirect_kind),
      .imm           (imm),
      .cmp_op        (cmp_op)
   );

   rvpc_branch_cmp rvpc_branch_cmp_i (
      .cmp_op   (cmp_op),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .taken    (taken)
   );

   rvpc_next_pc #(
      .reset_boot_pc (reset_boot_pc)
   ) rvpc_next_pc_i (
      .clk           (clk),
      .reset         (reset),
      .instr_valid   (instr_valid),
      .redirect_kind (redirect_kind),
      .imm           (imm),
      .taken         (taken),
      .rs1_data      (rs1_data),
      .pc            (pc),
      .redirect      (redirect),
      .cfg           (cfg_if_i.pc)
   );

   rvpc_csr_regs #(
      .reset_boot_pc     (reset_boot_pc),
      .reset_trap_vector (reset_trap_vector)
   ) rvpc_csr_regs_i (
      .clk     (clk),
      .reset   (reset),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .cfg     (cfg_if_i.csr)
   );

endmodule

/* dv/rvpc_tb.sv */
`timescale 1ns/10ps

module rvpc_tb;

   localparam int n_pairs        = 12;
   localparam int instr_steps    = 6*n_pairs + 60;
   localparam int axi_ops        = 40;
   // roughly 6 cycles per instruction step, 16 per register access
   localparam int test_cycles    = 8 + instr_steps*6 + axi_ops*16;
   localparam int timeout_cycles = 2*test_cycles;
   localparam logic [63:0] msb   = 64'h8000_0000_0000_0000;

   logic        clk;
   logic        reset;
   logic        instr_valid;
   logic [31:0] instr;
   logic [63:0] rs1_data;
   logic [63:0] rs2_data;
   logic [63:0] pc;
   logic        redirect;
   logic [7:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [7:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   logic [31:0] rng = 32'hc37f;
   logic [63:0] exp_pc;
   logic [63:0] boot_model;
   logic [63:0] trap_model;
   logic [31:0] cnt_model;
   int          cycle_cnt = 0;

   rvpc_top rvpc_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= timeout_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("** FAIL **");
         $fatal(1, "simulation stopped by the cycle limit");
      end
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [63:0] rand64();
      return {next_rand(), next_rand()};
   endfunction

   function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] imm);
      return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
   endfunction

   function automatic logic [31:0] enc_jalr(input logic [11:0] imm);
      return {imm, 5'd1, 3'b000, 5'd1, 7'b1100111};
   endfunction

   function automatic logic branch_holds(input logic [2:0] f3, input logic [63:0] a,
                                         input logic [63:0] b);
      case (f3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return (a ^ msb) < (b ^ msb); // signed order by offsetting the sign bit
         3'b101:  return !((a ^ msb) < (b ^ msb));
         3'b110:  return a < b;
         3'b111:  return !(a < b);
         default: return 1'b0;
      endcase
   endfunction

   // expected next pc and redirect for one instruction at exp_pc
   task automatic model_target(input logic [31:0] w, input logic [63:0] a,
                               input logic [63:0] b, output logic [63:0] tgt,
                               output logic redir);
      logic [63:0] imm;
      tgt   = exp_pc + 64'd4;
      redir = 1'b0;
      case (w[6:0])
         7'b1100011: begin
            imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            if (branch_holds(w[14:12], a, b)) begin
               tgt   = exp_pc + imm;
               redir = 1'b1;
            end
         end
         7'b1101111: begin
            imm   = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            tgt   = exp_pc + imm;
            redir = 1'b1;
         end
         7'b1100111: begin
            imm   = {{52{w[31]}}, w[31:20]};
            tgt   = (a + imm) & ~64'd1;
            redir = 1'b1;
         end
         7'b1110011: begin
            if (w == 32'h0010_0073) begin
               tgt   = trap_model;
               redir = 1'b1;
            end
         end
         default: ;
      endcase
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
         $display("** FAIL **");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic run_instr(input logic [31:0] word, input logic [63:0] a,
                            input logic [63:0] b);
      logic [63:0] tgt;
      logic        redir;
      model_target(word, a, b, tgt, redir);
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= word;
      rs1_data    <= a;
      rs2_data    <= b;
      @(posedge clk);
      instr_valid <= 1'b0;
      @(negedge clk);
      check("pc", pc, tgt);
      check("redirect", redirect, redir);
      exp_pc = tgt;
      if (redir) begin
         cnt_model++;
      end
   endtask

   task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] exp_resp);
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= strb;
      wvalid  <= 1'b1;
      bready  <= 1'b1;
      @(negedge clk);
      while (!(awready && wready)) @(negedge clk);
      @(posedge clk); // handshake edge
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      check("bresp", bresp, exp_resp);
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [7:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      rready  <= 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      check("rdata", rdata, exp_data);
      check("rresp", rresp, exp_resp);
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic readback_all();
      axi_read(rvpc_pkg::reg_ctrl, 32'h0, rvpc_pkg::resp_okay);
      axi_read(rvpc_pkg::reg_boot_lo, boot_model[31:0], rvpc_pkg::resp_okay);
      axi_read(rvpc_pkg::reg_boot_hi, boot_model[63:32], rvpc_pkg::resp_okay);
      axi_read(rvpc_pkg::reg_trap_lo, trap_model[31:0], rvpc_pkg::resp_okay);
      axi_read(rvpc_pkg::reg_trap_hi, trap_model[63:32], rvpc_pkg::resp_okay);
      axi_read(rvpc_pkg::reg_redirects, cnt_model, rvpc_pkg::resp_okay);
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      check("pc", pc, 64'h8000_0000);
      check("redirect", redirect, 1'b0);
      check("awready", awready, 1'b0);
      check("wready", wready, 1'b0);
      check("arready", arready, 1'b0);
      check("bvalid", bvalid, 1'b0);
      check("rvalid", rvalid, 1'b0);
      readback_all();
   endtask

   task automatic test_branches();
      logic [2:0]  ops [6];
      logic [63:0] a;
      logic [63:0] b;
      logic [31:0] r;
      ops = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      for (int op = 0; op < 6; op++) begin
         for (int k = 0; k < n_pairs; k++) begin
            case (k % 6)
               0: begin
                  a = rand64();
                  b = rand64();
               end
               1: begin
                  a = rand64();
                  b = a;
               end
               2: begin
                  a = rand64() | msb;
                  b = rand64() & ~msb;
               end
               3: begin
                  a = rand64() & ~msb;
                  b = rand64() | msb;
               end
               4: begin
                  a = '0;
                  b = '1;
               end
               default: begin
                  a = '1;
                  b = msb;
               end
            endcase
            r = next_rand();
            run_instr(enc_b(ops[op], {r[12:1], 1'b0}), a, b);
         end
      end
      r = next_rand();
      run_instr(enc_b(3'b010, {r[12:1], 1'b0}), 64'd5, 64'd5); // no such branch
      run_instr(32'h00a0_0093, rand64(), rand64());              // addi
      run_instr(32'h0000_0073, rand64(), rand64());              // ecall falls through
   endtask

   task automatic test_jumps();
      logic [31:0] r;
      logic [63:0] hold_pc;
      for (int k = 0; k < 8; k++) begin
         r = next_rand();
         run_instr(enc_j({r[20:1], 1'b0}), rand64(), rand64());
         r = next_rand();
         run_instr(enc_jalr(r[11:0]), rand64(), rand64());
      end
      hold_pc = exp_pc;
      @(posedge clk);
      instr <= enc_j(21'h0_0100); // ignored while instr_valid is low
      repeat (3) @(negedge clk);
      check("pc", pc, hold_pc);
      check("redirect", redirect, 1'b0);
   endtask

   task automatic test_trap();
      trap_model = {next_rand(), next_rand() & 32'hffff_fffc};
      axi_write(rvpc_pkg::reg_trap_lo, trap_model[31:0], 4'hf, rvpc_pkg::resp_okay);
      axi_write(rvpc_pkg::reg_trap_hi, trap_model[63:32], 4'hf, rvpc_pkg::resp_okay);
      run_instr(32'h0010_0073, rand64(), rand64());
   endtask

   task automatic test_restart_count();
      boot_model = {next_rand(), next_rand() & 32'hffff_fffc};
      axi_write(rvpc_pkg::reg_boot_lo, boot_model[31:0], 4'hf, rvpc_pkg::resp_okay);
      axi_write(rvpc_pkg::reg_boot_hi, boot_model[63:32], 4'hf, rvpc_pkg::resp_okay);
      axi_write(rvpc_pkg::reg_boot_lo, 32'hffff_ff5c, 4'b0001, rvpc_pkg::resp_okay);
      boot_model[7:0] = 8'h5c; // only byte 0 enabled
      axi_read(rvpc_pkg::reg_boot_lo, boot_model[31:0], rvpc_pkg::resp_okay);
      axi_write(rvpc_pkg::reg_ctrl, 32'h1, 4'hf, rvpc_pkg::resp_okay);
      @(negedge clk); // two cycles after the handshake
      check("pc", pc, boot_model);
      check("redirect", redirect, 1'b0);
      exp_pc    = boot_model;
      cnt_model = '0;
      for (int k = 0; k < 4; k++) begin
         run_instr(enc_j(21'h0_0040), '0, '0);
         run_instr(enc_b(3'b000, 13'h0010), 64'd7, 64'd7);
         run_instr(enc_b(3'b001, 13'h0010), 64'd7, 64'd7);
         run_instr(32'h00a0_0093, '0, '0);
      end
      axi_read(rvpc_pkg::reg_redirects, cnt_model, rvpc_pkg::resp_okay);
      axi_write(8'h18, 32'hdead_beef, 4'hf, rvpc_pkg::resp_slverr);
      axi_read(8'h18, 32'h0, rvpc_pkg::resp_slverr);
      axi_write(8'h40, 32'h1, 4'hf, rvpc_pkg::resp_slverr);
      readback_all();
   endtask

   initial begin
      reset       = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      rs1_data    = '0;
      rs2_data    = '0;
      awaddr      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      exp_pc      = 64'h8000_0000;
      boot_model  = 64'h8000_0000;
      trap_model  = 64'h8000_0100;
      cnt_model   = '0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      test_reset_state();
      test_branches();
      test_jumps();
      test_trap();
      test_restart_count();
      $display("** PASS **");
      $finish;
   end

endmodule

/* sources.f */
design/rvpc_pkg.sv
design/rvpc_cfg_if.sv
design/rvpc_instr_decode.sv
design/rvpc_branch_cmp.sv
design/rvpc_next_pc.sv
design/rvpc_csr_regs.sv
design/rvpc_top.sv
dv/rvpc_tb.sv
